//--- src.f
+incdir+verilog
+incdir+test
verilog/spi_link_pkg.sv
verilog/pu_bus_pkg.sv
verilog/spi_slave_driver.sv
verilog/spi_buffer.sv
verilog/frame_hoarder.sv
verilog/pu_slave_spi.sv
test/tb_pu_slave_spi.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_pu_slave_spi
FILELIST  := src.f
VFLAGS    := --binary --timing --assert -j 0
BUILD_DIR := obj_dir
BINARY    := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
HEADERS   := verilog/pu_spi_macros.svh test/spi_master_model.svh
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(HEADERS)

.PHONY: all run check clean

all: check

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BINARY)
	./$(BINARY) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status

check: run
	@if grep -q "Regression failed" $(LOG); then echo "Simulation failed"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/spi_master_model.svh
`ifndef SPI_MASTER_MODEL_SVH
`define SPI_MASTER_MODEL_SVH

// SPI master in mode 0, MSB first, all pins driven on falling clk

// Half an sclk period, in clk cycles
localparam int SCLK_HALF = 8;

task automatic wait_clocks(input int n);
    repeat (n) @(negedge clk);
endtask

// mosi changes while sclk is low, miso is taken at the rising sclk edge
task automatic shift_spi_byte(input spi_byte_t tx, output spi_byte_t rx);
    for (int i = `PU_SPI_WIDTH - 1; i >= 0; i--) begin
        mosi = tx[i];
        wait_clocks(SCLK_HALF);
        sclk = 1'b1;
        rx[i] = miso;
        wait_clocks(SCLK_HALF);
        sclk = 1'b0;
    end
endtask

// ----------------------------------------------------------------------
// One frame: all of mosi_q goes out, the slave's bytes land in miso_q
// ----------------------------------------------------------------------
task automatic run_spi_frame();
    spi_byte_t rx;
    miso_q.delete();
    cs = 1'b0;
    foreach (mosi_q[i]) begin
        shift_spi_byte(mosi_q[i], rx);
        miso_q.push_back(rx);
    end
    // sclk back low for half a period before cs releases
    wait_clocks(SCLK_HALF);
    cs = 1'b1;
    mosi = 1'b0;
endtask

`endif

//--- test/tb_pu_slave_spi.sv
`timescale 1ns/1ps
`include "pu_spi_macros.svh"

module tb_pu_slave_spi
    import spi_link_pkg::*;
    import pu_bus_pkg::*;
();
    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 3;
    localparam int NUM_FRAMES = 12;
    localparam int MAX_FRAME_BYTES = 36;
    localparam int BYTES = `PU_DATA_WIDTH / `PU_SPI_WIDTH;
    localparam int STOP_TIMEOUT = 32;
    localparam pu_attr_t ATTR_IDLE = pu_attr_t'(1 << `PU_ATTR_INVALID);

    logic      clk;
    logic      rst;
    logic      signal_cycle;
    logic      signal_wr;
    logic      signal_oe;
    pu_data_t  data_in;
    pu_attr_t  attr_in;
    pu_data_t  data_out;
    pu_attr_t  attr_out;
    logic      flag_start;
    logic      flag_stop;
    logic      mosi;
    logic      sclk;
    logic      cs;
    logic      miso;
    spi_byte_t mosi_q [$];
    spi_byte_t miso_q [$];
    pu_data_t  tx_exp [$];
    pu_data_t  rx_exp_data [$];
    bit        rx_exp_fin [$];
    int        seed;
    int        errors;
    int        checks;
    int        start_count;
    int        stop_count;

    `include "spi_master_model.svh"

    // Frame length plus writes, swap, drain and gaps
    localparam int FRAME_CLKS = MAX_FRAME_BYTES * `PU_SPI_WIDTH * 2 * SCLK_HALF + 200;
    localparam int WATCHDOG_NS = NUM_FRAMES * FRAME_CLKS * CLK_PERIOD + 2000;

    pu_slave_spi UUT (
        .clk          (clk),
        .rst          (rst),
        .signal_cycle (signal_cycle),
        .signal_wr    (signal_wr),
        .signal_oe    (signal_oe),
        .data_in      (data_in),
        .attr_in      (attr_in),
        .data_out     (data_out),
        .attr_out     (attr_out),
        .flag_start   (flag_start),
        .flag_stop    (flag_stop),
        .mosi         (mosi),
        .sclk         (sclk),
        .cs           (cs),
        .miso         (miso)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // Flag pulses, counted over the whole run
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            start_count <= 0;
            stop_count  <= 0;
        end else begin
            if (flag_start) start_count <= start_count + 1;
            if (flag_stop) stop_count <= stop_count + 1;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the test did not finish", WATCHDOG_NS);
        $display("Regression failed");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------
    // Transfer buffer keeps only the first PU_BUF_SIZE writes
    task automatic write_tx_words(input int count);
        logic [31:0] rnd;
        tx_exp.delete();
        for (int k = 0; k < count; k++) begin
            rnd = $random(seed);
            signal_wr = 1'b1;
            data_in = rnd;
            if (tx_exp.size() < `PU_BUF_SIZE) tx_exp.push_back(rnd);
            @(negedge clk);
        end
        signal_wr = 1'b0;
        data_in = '0;
    endtask

    task automatic store_rx_word(input pu_data_t word, input bit fin);
        if (rx_exp_data.size() < `PU_BUF_SIZE) begin
            rx_exp_data.push_back(word);
            rx_exp_fin.push_back(fin);
        end
    endtask

    // Big-endian words, plus one zero-padded closing word tagged SPI_FINISH
    task automatic predict_rx();
        pu_data_t word;
        int       fill;
        rx_exp_data.delete();
        rx_exp_fin.delete();
        word = '0;
        fill = 0;
        foreach (mosi_q[i]) begin
            word[`PU_DATA_WIDTH - 1 - `PU_SPI_WIDTH * fill -: `PU_SPI_WIDTH] = mosi_q[i];
            fill++;
            if (fill == BYTES) begin
                store_rx_word(word, 1'b0);
                word = '0;
                fill = 0;
            end
        end
        if (mosi_q.size() > 0) store_rx_word(word, 1'b1);
    endtask

    task automatic check_miso(input string tag);
        pu_data_t  word;
        spi_byte_t exp_byte;
        int        w;
        foreach (miso_q[k]) begin
            w = k / BYTES;
            word = (w < tx_exp.size()) ? tx_exp[w] : '0;
            exp_byte = word[`PU_DATA_WIDTH - 1 - `PU_SPI_WIDTH * (k % BYTES) -: `PU_SPI_WIDTH];
            check_value($sformatf("%s miso byte %0d", tag, k), 32'(exp_byte), 32'(miso_q[k]));
        end
    endtask

    task automatic drain_rx(input string tag);
        pu_attr_t exp_attr;
        int       n;
        n = 0;
        while (rx_exp_data.size() > 0) begin
            exp_attr = '0;
            exp_attr[`PU_ATTR_VALID] = 1'b1;
            exp_attr[`PU_ATTR_SPI_FINISH] = rx_exp_fin[0];
            exp_attr[`PU_ATTR_FULL] = (rx_exp_data.size() == `PU_BUF_SIZE);
            check_value($sformatf("%s rx %0d data", tag, n), rx_exp_data[0], data_out);
            check_value($sformatf("%s rx %0d attr", tag, n), 32'(exp_attr), 32'(attr_out));
            signal_oe = 1'b1;
            @(negedge clk);
            signal_oe = 1'b0;
            void'(rx_exp_data.pop_front());
            void'(rx_exp_fin.pop_front());
            n++;
        end
        // Surplus words must not show up behind the kept ones
        check_value($sformatf("%s attr after drain", tag), 32'(ATTR_IDLE), 32'(attr_out));
    endtask

    // ------------------------------------------------------------------
    // One frame: fill transfer buffer, swap, run SPI, check both sides
    // ------------------------------------------------------------------
    task automatic run_frame_test(input int f);
        logic [31:0] rnd;
        int          nbytes;
        int          start_before;
        int          stop_before;
        int          waited;
        string       tag;
        tag = $sformatf("frame %0d", f);
        rnd = $random(seed);
        write_tx_words(int'(rnd % 32'd8));
        signal_cycle = 1'b1;
        @(negedge clk);
        signal_cycle = 1'b0;
        @(negedge clk);
        // Whole words, a partial word, then an overflow of the receive FIFO
        case (f)
            0: nbytes = 2 * BYTES;
            1: nbytes = BYTES + 2;
            2: nbytes = MAX_FRAME_BYTES;
            default: begin
                rnd = $random(seed);
                nbytes = 1 + int'(rnd % 32'd24);
            end
        endcase
        mosi_q.delete();
        for (int i = 0; i < nbytes; i++) begin
            rnd = $random(seed);
            mosi_q.push_back(rnd[`PU_SPI_WIDTH-1:0]);
        end
        predict_rx();
        start_before = start_count;
        stop_before = stop_count;
        run_spi_frame();
        waited = 0;
        while (stop_count == stop_before && waited < STOP_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (stop_count == stop_before) begin
            errors++;
            $display("%s: flag_stop never pulsed after cs went high", tag);
        end
        check_miso(tag);
        drain_rx(tag);
        check_value($sformatf("%s flag_start pulses", tag), 32'd1,
                    32'(start_count - start_before));
        check_value($sformatf("%s flag_stop pulses", tag), 32'd1, 32'(stop_count - stop_before));
    endtask

    initial begin
        seed = 32'hc9d7;
        errors = 0;
        checks = 0;
        rst = 1'b1;
        signal_cycle = 1'b0;
        signal_wr = 1'b0;
        signal_oe = 1'b0;
        data_in = '0;
        attr_in = '0;
        mosi = 1'b0;
        sclk = 1'b0;
        cs = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        check_value("reset attr_out", 32'(ATTR_IDLE), 32'(attr_out));
        check_value("reset flag_start", 32'd0, 32'(flag_start));
        check_value("reset flag_stop", 32'd0, 32'(flag_stop));
        check_value("reset miso", 32'd0, 32'(miso));

        for (int f = 0; f < NUM_FRAMES; f++) begin
            run_frame_test(f);
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- verilog/pu_slave_spi.sv
`timescale 1ns/1ps
`include "pu_spi_macros.svh"

module pu_slave_spi
    import spi_link_pkg::*;
    import pu_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     signal_cycle,
    input  logic     signal_wr,
    input  logic     signal_oe,
    input  pu_data_t data_in,
    input  pu_attr_t attr_in,
    output pu_data_t data_out,
    output pu_attr_t attr_out,
    output logic     flag_start,
    output logic     flag_stop,
    input  logic     mosi,
    input  logic     sclk,
    input  logic     cs,
    output logic     miso
);
    spi_pins_t   pins;
    spi_byte_t   rx_byte;
    spi_byte_t   tx_byte;
    logic        ready;
    logic        cs_sync;
    logic        cs_prev;
    logic        work_buffer_send;
    logic        swap;
    pu_data_t    tx_out [2];
    buf_status_t tx_status [2];
    pu_data_t    tx_word;
    logic        tx_pop;
    pu_tagged_t  rx_word;
    pu_tagged_t  rx_head;
    logic        rx_push;
    buf_status_t rx_status;

    assign pins = '{mosi: mosi, sclk: sclk, cs: cs};

    spi_slave_driver u_driver (
        .clk      (clk),
        .rst      (rst),
        .pins     (pins),
        .data_in  (tx_byte),
        .data_out (rx_byte),
        .ready    (ready),
        .cs_sync  (cs_sync),
        .miso     (miso)
    );

    // ------------------------------------------------------------------
    // Double-buffered transmit: one takes signal_wr, the other sends
    // ------------------------------------------------------------------
    assign swap = signal_cycle && cs;

    for (genvar i = 0; i < 2; i++) begin : gen_tx
        spi_buffer #(.payload_t(pu_data_t), .depth(`PU_BUF_SIZE)) u_tx_buffer (
            .clk      (clk),
            .rst      (rst),
            .push     (signal_wr && work_buffer_send != 1'(i)),
            .data_in  (data_in),
            .pop      (tx_pop && work_buffer_send == 1'(i)),
            // Old send buffer turns into the empty transfer buffer
            .clear    (swap && work_buffer_send == 1'(i)),
            .data_out (tx_out[i]),
            .status   (tx_status[i])
        );
    end

    assign tx_word = tx_out[work_buffer_send];

    frame_hoarder u_hoarder (
        .clk        (clk),
        .rst        (rst),
        .flag_start (flag_start),
        .flag_stop  (flag_stop),
        .ready      (ready),
        .rx_byte    (rx_byte),
        .tx_byte    (tx_byte),
        .tx_word    (tx_word),
        .tx_empty   (tx_status[work_buffer_send].empty),
        .tx_pop     (tx_pop),
        .rx_word    (rx_word),
        .rx_push    (rx_push)
    );

    spi_buffer #(.payload_t(pu_tagged_t), .depth(`PU_BUF_SIZE)) u_rx_buffer (
        .clk      (clk),
        .rst      (rst),
        .push     (rx_push),
        .data_in  (rx_word),
        .pop      (signal_oe),
        .clear    (1'b0),
        .data_out (rx_head),
        .status   (rx_status)
    );

    // ------------------------------------------------------------------
    // Frame flags and role register
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cs_prev          <= 1'b1;
            flag_start       <= 1'b0;
            flag_stop        <= 1'b0;
            work_buffer_send <= 1'b0;
        end else begin
            cs_prev    <= cs_sync;
            flag_start <= cs_prev && !cs_sync;
            flag_stop  <= !cs_prev && cs_sync;
            if (swap) begin
                work_buffer_send <= !work_buffer_send;
            end
        end
    end

    // System view of the receive FIFO head
    assign data_out = rx_head.data;

    always_comb begin
        attr_out = '0;
        attr_out[`PU_ATTR_INVALID]    = rx_status.empty;
        attr_out[`PU_ATTR_VALID]      = !rx_status.empty;
        attr_out[`PU_ATTR_SPI_FINISH] = rx_head.attr[`PU_ATTR_SPI_FINISH];
        attr_out[`PU_ATTR_FULL]       = rx_status.full;
    end

    // No attribute is defined on the write path
    a_attr_in_zero: assert property (@(posedge clk) disable iff (rst) attr_in == '0);

endmodule

//--- verilog/frame_hoarder.sv
`timescale 1ns/1ps
`include "pu_spi_macros.svh"

module frame_hoarder
    import spi_link_pkg::*;
    import pu_bus_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       flag_start,
    input  logic       flag_stop,
    input  logic       ready,
    input  spi_byte_t  rx_byte,
    output spi_byte_t  tx_byte,
    input  pu_data_t   tx_word,
    input  logic       tx_empty,
    output logic       tx_pop,
    output pu_tagged_t rx_word,
    output logic       rx_push
);
    localparam int BYTES = `PU_DATA_WIDTH / `PU_SPI_WIDTH;
    localparam int IDX_W = $clog2(BYTES);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(BYTES - 1);

    pu_data_t         tx_reg;
    logic [IDX_W-1:0] tx_idx;
    logic             tx_load;
    pu_data_t         rx_acc;
    logic [IDX_W-1:0] rx_cnt;
    logic             rx_any;
    pu_data_t         rx_padded;

    // ------------------------------------------------------------------
    // Transmit side
    // ------------------------------------------------------------------
    // New word at frame start and after the last byte of each word
    assign tx_load = flag_start || (ready && tx_idx == LAST_IDX);
    assign tx_pop  = tx_load && !tx_empty;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx_idx <= '0;
        end else if (tx_load) begin
            tx_idx <= '0;
        end else if (ready) begin
            tx_idx <= tx_idx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tx_load) begin
            tx_reg <= tx_empty ? '0 : tx_word;
        end
    end

    // Driver loads the first byte while flag_start is high,
    // so it comes straight from the buffer head
    always_comb begin
        if (flag_start) begin
            tx_byte = tx_empty ? '0 : tx_word[`PU_DATA_WIDTH-1 -: `PU_SPI_WIDTH];
        end else begin
            tx_byte = tx_reg[`PU_SPI_WIDTH * (LAST_IDX - tx_idx) +: `PU_SPI_WIDTH];
        end
    end

    // ------------------------------------------------------------------
    // Receive side
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_cnt <= '0;
            rx_any <= 1'b0;
        end else if (flag_start || flag_stop) begin
            rx_cnt <= '0;
            rx_any <= 1'b0;
        end else if (ready) begin
            rx_cnt <= (rx_cnt == LAST_IDX) ? '0 : rx_cnt + 1'b1;
            rx_any <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ready) begin
            rx_acc <= {rx_acc[`PU_DATA_WIDTH-`PU_SPI_WIDTH-1:0], rx_byte};
        end
    end

    // Leftover bytes moved to the top, zero when the frame ended on a word
    assign rx_padded = rx_acc << (`PU_SPI_WIDTH * (BYTES - int'(rx_cnt)));

    // Every frame that carried data closes with one SPI_FINISH word
    assign rx_push = (ready && rx_cnt == LAST_IDX) || (flag_stop && rx_any);

    always_comb begin
        rx_word = '0;
        rx_word.attr[`PU_ATTR_VALID] = 1'b1;
        if (flag_stop) begin
            rx_word.data = rx_padded;
            rx_word.attr[`PU_ATTR_SPI_FINISH] = 1'b1;
        end else begin
            rx_word.data = {rx_acc[`PU_DATA_WIDTH-`PU_SPI_WIDTH-1:0], rx_byte};
        end
    end

endmodule

//--- verilog/spi_buffer.sv
`timescale 1ns/1ps
`include "pu_spi_macros.svh"

module spi_buffer
    import pu_bus_pkg::*;
#(
    parameter type payload_t = pu_data_t,
    parameter int  depth     = `PU_BUF_SIZE
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        push,
    input  payload_t    data_in,
    input  logic        pop,
    input  logic        clear,
    output payload_t    data_out,
    output buf_status_t status
);
    localparam int PTR_W = (depth > 1) ? $clog2(depth) : 1;
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(depth - 1);

    payload_t             mem [depth];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [BUF_CNT_W-1:0] count;
    logic                 empty;
    logic                 full;
    logic                 do_push;
    logic                 do_pop;

    assign empty   = (count == '0);
    assign full    = (count == BUF_CNT_W'(depth));
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    // Head shows through without a pop, zero once drained
    assign data_out = empty ? '0 : mem[rd_ptr];
    assign status   = '{empty: empty, full: full, count: count};

    a_count_bound: assert property (@(posedge clk) disable iff (rst) count <= BUF_CNT_W'(depth));

    // A full buffer stays full until something is popped or cleared
    a_full_holds: assert property (@(posedge clk) disable iff (rst)
        (full && !pop && !clear) |=> full);

endmodule

//--- verilog/spi_slave_driver.sv
`timescale 1ns/1ps
`include "pu_spi_macros.svh"

module spi_slave_driver
    import spi_link_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  spi_pins_t pins,
    input  spi_byte_t data_in,
    output spi_byte_t data_out,
    output logic      ready,
    output logic      cs_sync,
    output logic      miso
);
    localparam int MSB = `PU_SPI_WIDTH - 1;
    localparam int BIT_W = $clog2(`PU_SPI_WIDTH);
    localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(`PU_SPI_WIDTH - 1);
    localparam spi_pins_t PINS_IDLE = '{mosi: 1'b0, sclk: 1'b0, cs: 1'b1};

    spi_pins_t        pins_meta;
    spi_pins_t        pins_sync;
    spi_pins_t        pins_prev;
    logic             sclk_rise;
    logic             sclk_fall;
    logic             cs_fall;
    logic             load_first;
    logic             byte_fall;
    logic [BIT_W-1:0] bit_cnt;
    spi_byte_t        shift_in;
    spi_byte_t        shift_out;

    // ------------------------------------------------------------------
    // Two-flop synchronizer, plus one more stage for edge detection
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pins_meta <= PINS_IDLE;
            pins_sync <= PINS_IDLE;
            pins_prev <= PINS_IDLE;
        end else begin
            pins_meta <= pins;
            pins_sync <= pins_meta;
            pins_prev <= pins_sync;
        end
    end

    assign sclk_rise = pins_sync.sclk && !pins_prev.sclk;
    assign sclk_fall = !pins_sync.sclk && pins_prev.sclk && !pins_sync.cs;
    assign cs_fall   = !pins_sync.cs && pins_prev.cs;
    assign cs_sync   = pins_sync.cs;

    // Falling edge that closes a byte, next byte goes out from here
    assign byte_fall = sclk_fall && (bit_cnt == '0);

    // ------------------------------------------------------------------
    // Bit counter, ready strobe and miso
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bit_cnt    <= '0;
            ready      <= 1'b0;
            load_first <= 1'b0;
            miso       <= 1'b0;
        end else begin
            ready      <= 1'b0;
            load_first <= cs_fall;
            if (pins_sync.cs) begin
                bit_cnt <= '0;
            end else if (sclk_rise) begin
                bit_cnt <= (bit_cnt == LAST_BIT) ? '0 : bit_cnt + 1'b1;
                ready   <= (bit_cnt == LAST_BIT);
            end
            if (pins_sync.cs) begin
                miso <= 1'b0;
            end else if (load_first || byte_fall) begin
                miso <= data_in[MSB];
            end else if (sclk_fall) begin
                miso <= shift_out[MSB];
            end
        end
    end

    // Shift registers, MSB first in both directions
    always_ff @(posedge clk) begin
        if (sclk_rise && !pins_sync.cs) begin
            shift_in <= {shift_in[MSB-1:0], pins_sync.mosi};
            if (bit_cnt == LAST_BIT) begin
                data_out <= {shift_in[MSB-1:0], pins_sync.mosi};
            end
        end
        if (load_first || byte_fall) begin
            shift_out <= {data_in[MSB-1:0], 1'b0};
        end else if (sclk_fall) begin
            shift_out <= {shift_out[MSB-1:0], 1'b0};
        end
    end

    // A byte can only complete inside a frame
    a_ready_in_frame: assert property (@(posedge clk) disable iff (rst) ready |-> !cs_sync);

endmodule

//--- verilog/pu_bus_pkg.sv
`include "pu_spi_macros.svh"

package pu_bus_pkg;

    // Width of a buffer fill level, 0 up to the full depth
    localparam int BUF_CNT_W = $clog2(`PU_BUF_SIZE + 1);

    typedef logic [`PU_DATA_WIDTH-1:0] pu_data_t;
    typedef logic [`PU_ATTR_WIDTH-1:0] pu_attr_t;

    // Receive payload: word plus its attribute bits
    typedef struct packed {
        pu_data_t data;
        pu_attr_t attr;
    } pu_tagged_t;

    typedef struct packed {
        logic                 empty;
        logic                 full;
        logic [BUF_CNT_W-1:0] count;
    } buf_status_t;

endpackage

//--- verilog/spi_link_pkg.sv
`include "pu_spi_macros.svh"

package spi_link_pkg;

    // One byte as it moves over mosi or miso
    typedef logic [`PU_SPI_WIDTH-1:0] spi_byte_t;

    // SPI pins, sampled together through the synchronizer
    typedef struct packed {
        logic mosi;
        logic sclk;
        logic cs;
    } spi_pins_t;

endpackage

//--- verilog/pu_spi_macros.svh
`ifndef PU_SPI_MACROS_SVH
`define PU_SPI_MACROS_SVH

// Word, attribute and SPI byte widths
`define PU_DATA_WIDTH 32
`define PU_ATTR_WIDTH 4
`define PU_SPI_WIDTH 8

// Depth of every word buffer, in words
`define PU_BUF_SIZE 6

// Attribute bit positions
`define PU_ATTR_INVALID 0
`define PU_ATTR_VALID 1
`define PU_ATTR_SPI_FINISH 2
`define PU_ATTR_FULL 3

`endif
